/* verilog/des_params.svh */
/*
 * DES engine sizes
 * Widths of the data block, halves, key, key halves and round keys,
 * and the number of Feistel rounds
 */
`ifndef DES_PARAMS_SVH
`define DES_PARAMS_SVH

// Data path
`define DES_BLOCK_W   64
`define DES_HALF_W    32

// Key path
`define DES_KEY_W     64
`define DES_CD_W      28
`define DES_SUBKEY_W  48

// Round sequencing
`define DES_ROUNDS    16
`define DES_ROUND_W   4

`endif

/* verilog/des_types_pkg.sv */
/*
 * DES shared types
 * Data block, halves, key schedule words and the S-box input word
 */
`include "des_params.svh"

package des_types_pkg;

	typedef logic [`DES_BLOCK_W-1:0]  block_t;
	typedef logic [`DES_HALF_W-1:0]   half_t;
	typedef logic [`DES_CD_W-1:0]     cd_t;
	typedef logic [`DES_SUBKEY_W-1:0] subkey_t;
	typedef logic [`DES_ROUND_W-1:0]  round_t;

	// Six bits cut from the keyed expansion, outer bits pick the row
	typedef union packed {
		logic [5:0] raw;
		struct packed {
			logic       row_hi;
			logic [3:0] column;
			logic       row_lo;
		} fields;
	} sbox_in_u;

endpackage

/* verilog/des_tables_pkg.sv */
/*
 * DES cipher tables
 * Permutation source indices, shift schedule and S-box contents.
 * Index 63 (or the top bit of a narrower word) is FIPS bit 1
 */
`include "des_params.svh"

package des_tables_pkg;

	// --------------------
	// Block permutations
	localparam int ip_tab [`DES_BLOCK_W] = '{
		6, 14, 22, 30, 38, 46, 54, 62,  4, 12, 20, 28, 36, 44, 52, 60,
		2, 10, 18, 26, 34, 42, 50, 58,  0,  8, 16, 24, 32, 40, 48, 56,
		7, 15, 23, 31, 39, 47, 55, 63,  5, 13, 21, 29, 37, 45, 53, 61,
		3, 11, 19, 27, 35, 43, 51, 59,  1,  9, 17, 25, 33, 41, 49, 57
	};

	localparam int fp_tab [`DES_BLOCK_W] = '{
		24, 56, 16, 48,  8, 40,  0, 32, 25, 57, 17, 49,  9, 41,  1, 33,
		26, 58, 18, 50, 10, 42,  2, 34, 27, 59, 19, 51, 11, 43,  3, 35,
		28, 60, 20, 52, 12, 44,  4, 36, 29, 61, 21, 53, 13, 45,  5, 37,
		30, 62, 22, 54, 14, 46,  6, 38, 31, 63, 23, 55, 15, 47,  7, 39
	};

	// --------------------
	// Round function
	localparam int e_tab [`DES_SUBKEY_W] = '{
		 0, 31, 30, 29, 28, 27, 28, 27, 26, 25, 24, 23,
		24, 23, 22, 21, 20, 19, 20, 19, 18, 17, 16, 15,
		16, 15, 14, 13, 12, 11, 12, 11, 10,  9,  8,  7,
		 8,  7,  6,  5,  4,  3,  4,  3,  2,  1,  0, 31
	};

	localparam int p_tab [`DES_HALF_W] = '{
		16, 25, 12, 11,  3, 20,  4, 15, 31, 17,  9,  6, 27, 14,  1, 22,
		30, 24,  8, 18,  0,  5, 29, 23, 13, 19,  2, 26, 10, 21, 28,  7
	};

	// --------------------
	// Key schedule
	// C half first, then D half
	localparam int pc1_tab [2*`DES_CD_W] = '{
		 7, 15, 23, 31, 39, 47, 55, 63,  6, 14, 22, 30, 38, 46,
		54, 62,  5, 13, 21, 29, 37, 45, 53, 61,  4, 12, 20, 28,
		 1,  9, 17, 25, 33, 41, 49, 57,  2, 10, 18, 26, 34, 42,
		50, 58,  3, 11, 19, 27, 35, 43, 51, 59, 36, 44, 52, 60
	};

	localparam int pc2_tab [`DES_SUBKEY_W] = '{
		42, 39, 45, 32, 55, 51, 53, 28, 41, 50, 35, 46,
		33, 37, 44, 52, 30, 48, 40, 49, 29, 36, 43, 54,
		15,  4, 25, 19,  9,  1, 26, 16,  5, 11, 23,  8,
		12,  7, 17,  0, 22,  3, 10, 14,  6, 20, 27, 24
	};

	localparam int shift_tab [`DES_ROUNDS] = '{
		1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1
	};

	// --------------------
	// S-boxes, [box][row][column]
	localparam logic [3:0] sbox_tab [8][4][16] = '{
		'{'{14,  4, 13,  1,  2, 15, 11,  8,  3, 10,  6, 12,  5,  9,  0,  7},
		  '{ 0, 15,  7,  4, 14,  2, 13,  1, 10,  6, 12, 11,  9,  5,  3,  8},
		  '{ 4,  1, 14,  8, 13,  6,  2, 11, 15, 12,  9,  7,  3, 10,  5,  0},
		  '{15, 12,  8,  2,  4,  9,  1,  7,  5, 11,  3, 14, 10,  0,  6, 13}},
		'{'{15,  1,  8, 14,  6, 11,  3,  4,  9,  7,  2, 13, 12,  0,  5, 10},
		  '{ 3, 13,  4,  7, 15,  2,  8, 14, 12,  0,  1, 10,  6,  9, 11,  5},
		  '{ 0, 14,  7, 11, 10,  4, 13,  1,  5,  8, 12,  6,  9,  3,  2, 15},
		  '{13,  8, 10,  1,  3, 15,  4,  2, 11,  6,  7, 12,  0,  5, 14,  9}},
		'{'{10,  0,  9, 14,  6,  3, 15,  5,  1, 13, 12,  7, 11,  4,  2,  8},
		  '{13,  7,  0,  9,  3,  4,  6, 10,  2,  8,  5, 14, 12, 11, 15,  1},
		  '{13,  6,  4,  9,  8, 15,  3,  0, 11,  1,  2, 12,  5, 10, 14,  7},
		  '{ 1, 10, 13,  0,  6,  9,  8,  7,  4, 15, 14,  3, 11,  5,  2, 12}},
		'{'{ 7, 13, 14,  3,  0,  6,  9, 10,  1,  2,  8,  5, 11, 12,  4, 15},
		  '{13,  8, 11,  5,  6, 15,  0,  3,  4,  7,  2, 12,  1, 10, 14,  9},
		  '{10,  6,  9,  0, 12, 11,  7, 13, 15,  1,  3, 14,  5,  2,  8,  4},
		  '{ 3, 15,  0,  6, 10,  1, 13,  8,  9,  4,  5, 11, 12,  7,  2, 14}},
		'{'{ 2, 12,  4,  1,  7, 10, 11,  6,  8,  5,  3, 15, 13,  0, 14,  9},
		  '{14, 11,  2, 12,  4,  7, 13,  1,  5,  0, 15, 10,  3,  9,  8,  6},
		  '{ 4,  2,  1, 11, 10, 13,  7,  8, 15,  9, 12,  5,  6,  3,  0, 14},
		  '{11,  8, 12,  7,  1, 14,  2, 13,  6, 15,  0,  9, 10,  4,  5,  3}},
		'{'{12,  1, 10, 15,  9,  2,  6,  8,  0, 13,  3,  4, 14,  7,  5, 11},
		  '{10, 15,  4,  2,  7, 12,  9,  5,  6,  1, 13, 14,  0, 11,  3,  8},
		  '{ 9, 14, 15,  5,  2,  8, 12,  3,  7,  0,  4, 10,  1, 13, 11,  6},
		  '{ 4,  3,  2, 12,  9,  5, 15, 10, 11, 14,  1,  7,  6,  0,  8, 13}},
		'{'{ 4, 11,  2, 14, 15,  0,  8, 13,  3, 12,  9,  7,  5, 10,  6,  1},
		  '{13,  0, 11,  7,  4,  9,  1, 10, 14,  3,  5, 12,  2, 15,  8,  6},
		  '{ 1,  4, 11, 13, 12,  3,  7, 14, 10, 15,  6,  8,  0,  5,  9,  2},
		  '{ 6, 11, 13,  8,  1,  4, 10,  7,  9,  5,  0, 15, 14,  2,  3, 12}},
		'{'{13,  2,  8,  4,  6, 15, 11,  1, 10,  9,  3, 14,  5,  0, 12,  7},
		  '{ 1, 15, 13,  8, 10,  3,  7,  4, 12,  5,  6, 11,  0, 14,  9,  2},
		  '{ 7, 11,  4,  1,  9, 12, 14,  2,  0,  6, 10, 13, 15,  3,  5,  8},
		  '{ 2,  1, 14,  7,  4, 10,  8, 13, 15, 12,  9,  0,  3,  5,  6, 11}}
	};

endpackage

/* verilog/des_input_stage.sv */
/*
 * DES input stage
 * Captures block, key and direction on start and presents
 * L0/R0 after the initial permutation and C0/D0 after PC1
 */
`timescale 1ns/1ps
`include "des_params.svh"

module des_input_stage (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      start,
	input  logic                      encipher_en,
	input  des_types_pkg::block_t     data,
	input  logic [`DES_KEY_W-1:0]     key,
	output des_types_pkg::half_t      l0,
	output des_types_pkg::half_t      r0,
	output des_types_pkg::cd_t        c0,
	output des_types_pkg::cd_t        d0,
	output logic                      decrypt
);

	des_types_pkg::block_t     data_q;
	logic [`DES_KEY_W-1:0]     key_q;
	des_types_pkg::block_t     ip_out;
	logic [2*`DES_CD_W-1:0]    pc1_out;

	always_ff @(posedge clk) begin
		if (start) begin
			data_q <= data;
			key_q  <= key;
		end
	end

	// Encryption wins when both strobes arrive together
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			decrypt <= 1'b0;
		else if (start)
			decrypt <= ~encipher_en;
	end

	always_comb begin
		for (int i = 0; i < `DES_BLOCK_W; i++)
			ip_out[`DES_BLOCK_W-1-i] = data_q[des_tables_pkg::ip_tab[i]];
		for (int i = 0; i < 2*`DES_CD_W; i++)
			pc1_out[2*`DES_CD_W-1-i] = key_q[des_tables_pkg::pc1_tab[i]];
	end

	assign l0 = ip_out[`DES_BLOCK_W-1:`DES_HALF_W];
	assign r0 = ip_out[`DES_HALF_W-1:0];
	assign c0 = pc1_out[2*`DES_CD_W-1:`DES_CD_W];
	assign d0 = pc1_out[`DES_CD_W-1:0];

endmodule

/* verilog/des_control.sv */
/*
 * DES control
 * Accepts a strobe while idle, runs the round counter over
 * sixteen active cycles and flags the end of the rounds
 */
`timescale 1ns/1ps
`include "des_params.svh"

module des_control (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    encipher_en,
	input  logic                    decipher_en,
	output logic                    start,
	output logic                    active,
	output des_types_pkg::round_t   round,
	output logic                    rounds_done,
	output logic                    ready
);

	logic busy;
	logic last_round;

	assign ready = ~busy;

	// Strobes only count while idle
	assign start = ready & (encipher_en | decipher_en);

	assign last_round = active &
		(round == des_types_pkg::round_t'(`DES_ROUNDS - 1));

	// --------------------
	// Busy spans the rounds plus the output register cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy        <= 1'b0;
			active      <= 1'b0;
			round       <= '0;
			rounds_done <= 1'b0;
		end else begin
			rounds_done <= last_round;
			if (start) begin
				busy   <= 1'b1;
				active <= 1'b1;
				round  <= '0;
			end else begin
				if (active)
					round <= round + 1'b1;
				if (last_round)
					active <= 1'b0;
				if (rounds_done)
					busy <= 1'b0;
			end
		end
	end

endmodule

/* verilog/des_key_schedule.sv */
/*
 * DES key schedule
 * C/D register with left rotation for encryption and right
 * rotation for decryption, PC2 gives the round key
 */
`timescale 1ns/1ps
`include "des_params.svh"

module des_key_schedule (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    active,
	input  des_types_pkg::round_t   round,
	input  logic                    decrypt,
	input  des_types_pkg::cd_t      c0,
	input  des_types_pkg::cd_t      d0,
	output des_types_pkg::subkey_t  subkey
);

	des_types_pkg::cd_t     c_q, d_q;
	des_types_pkg::cd_t     src_c, src_d;
	des_types_pkg::cd_t     used_c, used_d;
	des_types_pkg::cd_t     next_c, next_d;
	des_types_pkg::round_t  back_idx;
	logic [2*`DES_CD_W-1:0] cd_used;

	function automatic des_types_pkg::cd_t rot_left(input des_types_pkg::cd_t x, input int n);
		return (x << n) | (x >> (`DES_CD_W - n));
	endfunction

	function automatic des_types_pkg::cd_t rot_right(input des_types_pkg::cd_t x, input int n);
		return (x >> n) | (x << (`DES_CD_W - n));
	endfunction

	// Decryption walks the shift schedule backwards
	assign back_idx = ~round;

	always_comb begin
		src_c = (round == '0) ? c0 : c_q;
		src_d = (round == '0) ? d0 : d_q;
		if (decrypt) begin
			used_c = src_c;
			used_d = src_d;
			next_c = rot_right(src_c, des_tables_pkg::shift_tab[back_idx]);
			next_d = rot_right(src_d, des_tables_pkg::shift_tab[back_idx]);
		end else begin
			used_c = rot_left(src_c, des_tables_pkg::shift_tab[round]);
			used_d = rot_left(src_d, des_tables_pkg::shift_tab[round]);
			next_c = used_c;
			next_d = used_d;
		end
		cd_used = {used_c, used_d};
		for (int i = 0; i < `DES_SUBKEY_W; i++)
			subkey[`DES_SUBKEY_W-1-i] = cd_used[des_tables_pkg::pc2_tab[i]];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			c_q <= '0;
			d_q <= '0;
		end else if (active) begin
			c_q <= next_c;
			d_q <= next_d;
		end
	end

endmodule

/* verilog/des_round.sv */
/*
 * DES round
 * L/R register and the f function: expansion, key mix,
 * eight S-box lookups and the P permutation
 */
`timescale 1ns/1ps
`include "des_params.svh"

module des_round (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    active,
	input  des_types_pkg::round_t   round,
	input  des_types_pkg::half_t    l0,
	input  des_types_pkg::half_t    r0,
	input  des_types_pkg::subkey_t  subkey,
	output des_types_pkg::half_t    l16,
	output des_types_pkg::half_t    r16
);

	des_types_pkg::half_t     l_q, r_q;
	des_types_pkg::half_t     l_src, r_src;
	des_types_pkg::subkey_t   r_exp;
	des_types_pkg::subkey_t   mixed;
	des_types_pkg::sbox_in_u  sb_in [8];
	des_types_pkg::half_t     s_out;
	des_types_pkg::half_t     f_val;

	assign l_src = (round == '0) ? l0 : l_q;
	assign r_src = (round == '0) ? r0 : r_q;

	always_comb begin
		for (int i = 0; i < `DES_SUBKEY_W; i++)
			r_exp[`DES_SUBKEY_W-1-i] = r_src[des_tables_pkg::e_tab[i]];
		mixed = r_exp ^ subkey;

		// S1 sits in the top six bits
		for (int b = 0; b < 8; b++) begin
			sb_in[b].raw = mixed[`DES_SUBKEY_W-1-6*b -: 6];
			s_out[`DES_HALF_W-1-4*b -: 4] = des_tables_pkg::sbox_tab[b]
				[{sb_in[b].fields.row_hi, sb_in[b].fields.row_lo}]
				[sb_in[b].fields.column];
		end

		for (int i = 0; i < `DES_HALF_W; i++)
			f_val[`DES_HALF_W-1-i] = s_out[des_tables_pkg::p_tab[i]];
	end

	// --------------------
	// Feistel step
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			l_q <= '0;
			r_q <= '0;
		end else if (active) begin
			l_q <= r_src;
			r_q <= l_src ^ f_val;
		end
	end

	assign l16 = l_q;
	assign r16 = r_q;

endmodule

/* verilog/des_output_stage.sv */
/*
 * DES output stage
 * Final permutation of the swapped halves, result register
 * and a one-cycle done pulse
 */
`timescale 1ns/1ps
`include "des_params.svh"

module des_output_stage (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  rounds_done,
	input  des_types_pkg::half_t  l16,
	input  des_types_pkg::half_t  r16,
	output des_types_pkg::block_t result,
	output logic                  done
);

	des_types_pkg::block_t pre_out;
	des_types_pkg::block_t fp_out;

	// Halves swap after the last round
	assign pre_out = {r16, l16};

	always_comb begin
		for (int i = 0; i < `DES_BLOCK_W; i++)
			fp_out[`DES_BLOCK_W-1-i] = pre_out[des_tables_pkg::fp_tab[i]];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result <= '0;
			done   <= 1'b0;
		end else begin
			done <= rounds_done;
			if (rounds_done)
				result <= fp_out;
		end
	end

endmodule

/* verilog/des_core.sv */
/*
 * DES core
 * Iterative DES engine, one Feistel round per clock, result
 * and done seventeen cycles after an accepted strobe
 */
`timescale 1ns/1ps
`include "des_params.svh"

module des_core (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   encipher_en,
	input  logic                   decipher_en,
	input  des_types_pkg::block_t  data,
	input  logic [`DES_KEY_W-1:0]  key,
	output des_types_pkg::block_t  result,
	output logic                   ready,
	output logic                   done
);

	logic                    start;
	logic                    active;
	logic                    rounds_done;
	logic                    decrypt;
	des_types_pkg::round_t   round;
	des_types_pkg::half_t    l0, r0;
	des_types_pkg::half_t    l16, r16;
	des_types_pkg::cd_t      c0, d0;
	des_types_pkg::subkey_t  subkey;

	des_input_stage u_input (
		.clk         (clk),
		.rst_n       (rst_n),
		.start       (start),
		.encipher_en (encipher_en),
		.data        (data),
		.key         (key),
		.l0          (l0),
		.r0          (r0),
		.c0          (c0),
		.d0          (d0),
		.decrypt     (decrypt)
	);

	des_control u_control (
		.clk         (clk),
		.rst_n       (rst_n),
		.encipher_en (encipher_en),
		.decipher_en (decipher_en),
		.start       (start),
		.active      (active),
		.round       (round),
		.rounds_done (rounds_done),
		.ready       (ready)
	);

	des_key_schedule u_key_schedule (
		.clk     (clk),
		.rst_n   (rst_n),
		.active  (active),
		.round   (round),
		.decrypt (decrypt),
		.c0      (c0),
		.d0      (d0),
		.subkey  (subkey)
	);

	des_round u_round (
		.clk    (clk),
		.rst_n  (rst_n),
		.active (active),
		.round  (round),
		.l0     (l0),
		.r0     (r0),
		.subkey (subkey),
		.l16    (l16),
		.r16    (r16)
	);

	des_output_stage u_output (
		.clk         (clk),
		.rst_n       (rst_n),
		.rounds_done (rounds_done),
		.l16         (l16),
		.r16         (r16),
		.result      (result),
		.done        (done)
	);

endmodule

/* verification/des_ref_model.svh */
/*
 * DES reference model
 * Bit-loop DES over the shared tables. All sixteen subkeys are
 * built first and walked backwards for decryption
 */
`ifndef DES_REF_MODEL_SVH
`define DES_REF_MODEL_SVH

function automatic logic [63:0] des_ref(
	input logic [63:0] blk,
	input logic [63:0] k,
	input logic        decrypt
);
	logic [63:0] ip_blk;
	logic [63:0] pre;
	logic [63:0] out;
	logic [55:0] cd;
	logic [27:0] c;
	logic [27:0] d;
	logic [47:0] ks [16];
	logic [47:0] rkey;
	logic [47:0] ex;
	logic [31:0] l;
	logic [31:0] r;
	logic [31:0] s;
	logic [31:0] f;
	logic [31:0] t;
	logic [5:0]  six;

	for (int i = 0; i < 64; i++)
		ip_blk[63-i] = blk[des_tables_pkg::ip_tab[i]];

	// --------------------
	// Forward key schedule
	for (int i = 0; i < 56; i++)
		cd[55-i] = k[des_tables_pkg::pc1_tab[i]];
	c = cd[55:28];
	d = cd[27:0];
	for (int rnd = 0; rnd < 16; rnd++) begin
		repeat (des_tables_pkg::shift_tab[rnd]) begin
			c = {c[26:0], c[27]};
			d = {d[26:0], d[27]};
		end
		cd = {c, d};
		for (int i = 0; i < 48; i++)
			ks[rnd][47-i] = cd[des_tables_pkg::pc2_tab[i]];
	end

	// --------------------
	// Sixteen Feistel rounds
	l = ip_blk[63:32];
	r = ip_blk[31:0];
	for (int rnd = 0; rnd < 16; rnd++) begin
		rkey = decrypt ? ks[15-rnd] : ks[rnd];
		for (int i = 0; i < 48; i++)
			ex[47-i] = r[des_tables_pkg::e_tab[i]];
		ex = ex ^ rkey;
		for (int b = 0; b < 8; b++) begin
			six = ex[47-6*b -: 6];
			s[31-4*b -: 4] = des_tables_pkg::sbox_tab[b][{six[5], six[0]}][six[4:1]];
		end
		for (int i = 0; i < 32; i++)
			f[31-i] = s[des_tables_pkg::p_tab[i]];
		t = r;
		r = l ^ f;
		l = t;
	end

	pre = {r, l};
	for (int i = 0; i < 64; i++)
		out[63-i] = pre[des_tables_pkg::fp_tab[i]];
	return out;
endfunction

`endif

/* verification/des_tb.sv */
/*
 * DES testbench
 * Known answer, random round trips in both directions, latency
 * and strobes arriving while the engine is busy
 */
`timescale 1ns/1ps
`include "des_params.svh"

module des_tb;

	logic                  clk;
	logic                  rst_n;
	logic                  encipher_en;
	logic                  decipher_en;
	des_types_pkg::block_t data;
	logic [`DES_KEY_W-1:0] key;
	des_types_pkg::block_t result;
	logic                  ready;
	logic                  done;

	integer                seed;
	string                 name_q [$];
	des_types_pkg::block_t exp_q [$];

	`include "des_ref_model.svh"

	des_core DUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.encipher_en (encipher_en),
		.decipher_en (decipher_en),
		.data        (data),
		.key         (key),
		.result      (result),
		.ready       (ready),
		.done        (done)
	);

	always #10 clk = ~clk;

	task automatic check(input string name, input logic [63:0] expected, input logic [63:0] actual);
		if (actual !== expected) begin
			$display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
			$display("CHECKS FAILED");
			$fatal(1);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout: %s within 40 cycles", what);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		while (!ready && n < 40) begin
			@(negedge clk);
			n++;
		end
		if (!ready)
			report_timeout("ready never rose");
	endtask

	// Extra strobes with other data while a block is in flight
	task automatic disturb(input int n, input des_types_pkg::block_t blk, input logic [63:0] k);
		case (n)
			2, 9, 16: begin
				encipher_en <= (n != 16);
				decipher_en <= (n != 9);
				data        <= blk ^ 64'h0f0f_0f0f_0f0f_0f0f;
				key         <= k ^ 64'h1234_5678_9abc_def0;
			end
			3, 10, 17: begin
				encipher_en <= 1'b0;
				decipher_en <= 1'b0;
			end
			default: ;
		endcase
	endtask

	task automatic run_block(
		input  string                 name,
		input  logic                  enc,
		input  logic                  dec,
		input  des_types_pkg::block_t blk,
		input  logic [63:0]           k,
		input  des_types_pkg::block_t expected,
		input  logic                  noise,
		output des_types_pkg::block_t res
	);
		int   n;
		logic seen;
		wait_ready();
		@(posedge clk);
		encipher_en <= enc;
		decipher_en <= dec;
		data        <= blk;
		key         <= k;
		name_q.push_back(name);
		exp_q.push_back(expected);
		// Inputs change right after the strobe edge
		@(posedge clk);
		encipher_en <= 1'b0;
		decipher_en <= 1'b0;
		data        <= ~blk;
		key         <= ~k;
		@(negedge clk);
		check({name, " ready low"}, 64'd0, 64'(ready));
		n = 0;
		seen = 1'b0;
		while (!seen && n < 40) begin
			@(posedge clk);
			n++;
			if (noise)
				disturb(n, blk, k);
			@(negedge clk);
			if (done)
				seen = 1'b1;
			else
				check({name, " ready low"}, 64'd0, 64'(ready));
		end
		if (!seen)
			report_timeout("done never rose");
		check({name, " latency"}, 64'd17, 64'(n));
		check({name, " ready with done"}, 64'd1, 64'(ready));
		res = result;
		@(negedge clk);
		check({name, " done width"}, 64'd0, 64'(done));
	endtask

	task automatic expect_idle(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			check("idle done", 64'd0, 64'(done));
			check("idle ready", 64'd1, 64'(ready));
		end
	endtask

	// --------------------
	// One expected value per accepted request
	always @(negedge clk) begin
		if (rst_n && done) begin
			if (exp_q.size() == 0) begin
				$display("Error: done pulsed with no request outstanding");
				$display("CHECKS FAILED");
				$fatal(1);
			end else begin
				check(name_q.pop_front(), exp_q.pop_front(), result);
			end
		end
	end

	initial begin
		des_types_pkg::block_t blk;
		des_types_pkg::block_t ct;
		logic [63:0]           k;
		seed        = 32'h8bca;
		clk         = 1'b0;
		rst_n       = 1'b0;
		encipher_en = 1'b0;
		decipher_en = 1'b0;
		data        = '0;
		key         = '0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check("reset ready", 64'd1, 64'(ready));
		check("reset done", 64'd0, 64'(done));
		check("reset result", 64'd0, result);

		// Known answer
		blk = 64'h0123_4567_89ab_cdef;
		k   = 64'h1334_5779_9bbc_dff1;
		check("kat reference", 64'h85e8_1354_0f0a_b405, des_ref(blk, k, 1'b0));
		run_block("kat encrypt", 1'b1, 1'b0, blk, k, 64'h85e8_1354_0f0a_b405, 1'b0, ct);
		run_block("kat decrypt", 1'b0, 1'b1, 64'h85e8_1354_0f0a_b405, k, blk, 1'b0, ct);

		// --------------------
		// Random blocks and keys
		for (int i = 0; i < 60; i++) begin
			blk = {$random(seed), $random(seed)};
			k   = {$random(seed), $random(seed)};
			run_block($sformatf("random encrypt %0d", i), 1'b1, 1'b0, blk, k,
				des_ref(blk, k, 1'b0), 1'b0, ct);
			run_block($sformatf("decrypt back %0d", i), 1'b0, 1'b1, ct, k, blk, 1'b0, ct);
		end
		for (int i = 0; i < 60; i++) begin
			blk = {$random(seed), $random(seed)};
			k   = {$random(seed), $random(seed)};
			run_block($sformatf("random decrypt %0d", i), 1'b0, 1'b1, blk, k,
				des_ref(blk, k, 1'b1), 1'b0, ct);
			run_block($sformatf("encrypt back %0d", i), 1'b1, 1'b0, ct, k, blk, 1'b0, ct);
		end

		// Both strobes at once and strobes while busy
		blk = {$random(seed), $random(seed)};
		k   = {$random(seed), $random(seed)};
		run_block("both strobes", 1'b1, 1'b1, blk, k, des_ref(blk, k, 1'b0), 1'b0, ct);
		run_block("busy encrypt", 1'b1, 1'b0, blk, k, des_ref(blk, k, 1'b0), 1'b1, ct);
		expect_idle(25);
		run_block("busy decrypt", 1'b0, 1'b1, blk, k, des_ref(blk, k, 1'b1), 1'b1, ct);
		expect_idle(25);

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+verilog
+incdir+verification
verilog/des_types_pkg.sv
verilog/des_tables_pkg.sv
verilog/des_input_stage.sv
verilog/des_control.sv
verilog/des_key_schedule.sv
verilog/des_round.sv
verilog/des_output_stage.sv
verilog/des_core.sv
verification/des_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= des_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it and look for the pass message"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
